//--- logic/apb_ctrl.sv
`timescale 1ns/1ps

module apb_ctrl #(
  parameter int imem_depth = 64
) (
  input  logic                                    clk,
  input  logic                                    arst_n,
  input  logic                                    psel,
  input  logic                                    penable,
  input  logic                                    pwrite,
  input  logic [cpu_bus_pkg::apb_addr_width-1:0]  paddr,
  input  logic [31:0]                             pwdata,
  output logic [31:0]                             prdata,
  output logic                                    pready,
  output logic                                    pslverr,
  input  logic                                    fetching,
  input  logic                                    f_valid,
  input  logic                                    d_valid,
  input  logic                                    wb_valid,
  output logic                                    imem_we,
  output logic [$clog2(imem_depth)-1:0]           imem_addr,
  output logic [31:0]                             imem_wdata,
  output logic                                    start,
  output logic [cpu_bus_pkg::count_width-1:0]     count,
  output logic [cpu_isa_pkg::reg_idx_width-1:0]   dbg_idx,
  input  logic [31:0]                             dbg_data
);
  import cpu_bus_pkg::*;

  logic access;
  logic word_aligned;
  logic imem_hit;
  logic reg_hit;
  logic ctrl_hit;
  logic busy;
  logic legal;
  logic accept;
  logic drained;
  logic running;
  logic done;

  assign access = psel && penable;
  assign pready = access;

  // Window decode, instruction window limited to the array depth
  assign word_aligned = paddr[1:0] == 2'b00;
  assign imem_hit = word_aligned && paddr[11:10] == imem_base[11:10]
                    && int'(paddr[9:2]) < imem_depth;
  assign reg_hit  = word_aligned && paddr[11:7] == reg_base[11:7];
  assign ctrl_hit = paddr == ctrl_addr;

  // Start cycle counts as busy so nothing slips in before running rises
  assign busy = running || start;

  // Instruction window is write-only, register window read-only
  assign legal = (imem_hit && pwrite && !busy)
              || (reg_hit && !pwrite && !busy)
              || (ctrl_hit && (!pwrite || !busy));
  assign pslverr = access && !legal;
  assign accept  = access && legal;

  assign imem_we    = accept && imem_hit;
  assign imem_addr  = paddr[2 +: $clog2(imem_depth)];
  assign imem_wdata = pwdata;
  assign dbg_idx    = paddr[2 +: $bits(dbg_idx)];

  always_comb
  begin
    prdata = '0;
    if (accept && !pwrite && reg_hit)
      prdata = dbg_data;
    else if (accept && !pwrite && ctrl_hit)
    begin
      prdata[count_width-1:0]  = count;
      prdata[stat_running_bit] = running;
      prdata[stat_done_bit]    = done;
    end
  end

  // Nothing left in flight anywhere in the pipeline
  assign drained = !fetching && !f_valid && !d_valid && !wb_valid;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      count   <= '0;
      start   <= 1'b0;
      running <= 1'b0;
      done    <= 1'b0;
    end
    else
    begin
      start <= 1'b0;
      if (accept && ctrl_hit && pwrite)
      begin
        count <= pwdata[count_width-1:0];
        start <= pwdata[ctrl_run_bit];
      end
      if (start)
      begin
        running <= 1'b1;
        done    <= 1'b0;
      end
      else if (running && drained)
      begin
        running <= 1'b0;
        done    <= 1'b1;
      end
    end
  end

endmodule

//--- logic/cpu_bus_pkg.sv
package cpu_bus_pkg;

  localparam int apb_addr_width = 12;

  // Windows in byte addresses, one 32-bit word per entry
  localparam logic [apb_addr_width-1:0] imem_base = 12'h000;
  localparam logic [apb_addr_width-1:0] reg_base  = 12'h400;
  localparam logic [apb_addr_width-1:0] ctrl_addr = 12'h800;

  // Control register fields
  localparam int count_width      = 8;
  localparam int ctrl_run_bit     = 31;
  localparam int stat_running_bit = 30;
  localparam int stat_done_bit    = 29;

endpackage

//--- logic/cpu_isa_pkg.sv
package cpu_isa_pkg;

  localparam int reg_idx_width = 5;

  // Executed opcodes, anything else retires as a no-op
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;

  localparam logic [2:0] funct3_add_sub = 3'b000;
  localparam logic [2:0] funct3_xor     = 3'b100;
  localparam logic [2:0] funct3_or      = 3'b110;
  localparam logic [2:0] funct3_and     = 3'b111;

  // Bit of funct7 that turns ADD into SUB
  localparam int funct7_sub = 5;

  // SUB shares alu_add and is selected by a separate flag
  typedef enum logic [1:0] {
    alu_add,
    alu_and,
    alu_or,
    alu_xor
  } alu_op_e;

  typedef union packed {
    struct packed {
      logic [6:0]               funct7;
      logic [reg_idx_width-1:0] rs2;
      logic [reg_idx_width-1:0] rs1;
      logic [2:0]               funct3;
      logic [reg_idx_width-1:0] rd;
      logic [6:0]               opcode;
    } r;
    struct packed {
      logic [11:0]              imm12;
      logic [reg_idx_width-1:0] rs1;
      logic [2:0]               funct3;
      logic [reg_idx_width-1:0] rd;
      logic [6:0]               opcode;
    } i;
  } instr_u;

endpackage

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  logic                                   f_valid,
  input  cpu_isa_pkg::instr_u                    f_instr,
  output logic [cpu_isa_pkg::reg_idx_width-1:0]  rf_rs1,
  output logic [cpu_isa_pkg::reg_idx_width-1:0]  rf_rs2,
  input  logic [31:0]                            rf_rs1_data,
  input  logic [31:0]                            rf_rs2_data,
  output logic                                   d_valid,
  output logic [cpu_isa_pkg::reg_idx_width-1:0]  d_rd,
  output logic [31:0]                            d_rs1_val,
  output logic [31:0]                            d_rs2_val,
  output logic [cpu_isa_pkg::reg_idx_width-1:0]  d_rs1,
  output logic [cpu_isa_pkg::reg_idx_width-1:0]  d_rs2,
  output logic [31:0]                            d_imm,
  output logic                                   d_use_imm,
  output cpu_isa_pkg::alu_op_e                   d_alu_op,
  output logic                                   d_sub,
  output logic                                   d_we
);
  import cpu_isa_pkg::*;

  logic    is_op;
  logic    is_op_imm;
  logic    known_f3;
  logic    sub;
  alu_op_e alu_op;

  assign rf_rs1 = f_instr.r.rs1;
  assign rf_rs2 = f_instr.r.rs2;

  always_comb
  begin
    is_op     = f_instr.r.opcode == opcode_op;
    is_op_imm = f_instr.i.opcode == opcode_op_imm;
    known_f3  = 1'b1;
    alu_op    = alu_add;
    // Shifts and compares are not implemented and retire as no-ops
    case (f_instr.r.funct3)
      funct3_add_sub: alu_op = alu_add;
      funct3_xor:     alu_op = alu_xor;
      funct3_or:      alu_op = alu_or;
      funct3_and:     alu_op = alu_and;
      default:        known_f3 = 1'b0;
    endcase
    // No SUBI, so the funct7 bit only counts in R-type
    sub = is_op && f_instr.r.funct3 == funct3_add_sub && f_instr.r.funct7[funct7_sub];
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      d_valid <= 1'b0;
      d_we    <= 1'b0;
    end
    else
    begin
      d_valid <= f_valid;
      d_we    <= f_valid && (is_op || is_op_imm) && known_f3 && f_instr.i.rd != '0;
    end
  end

  always_ff @(posedge clk)
  begin
    d_rd      <= f_instr.i.rd;
    d_rs1     <= f_instr.r.rs1;
    d_rs2     <= f_instr.r.rs2;
    d_rs1_val <= rf_rs1_data;
    d_rs2_val <= rf_rs2_data;
    d_imm     <= {{20{f_instr.i.imm12[11]}}, f_instr.i.imm12};
    d_use_imm <= is_op_imm;
    d_alu_op  <= alu_op;
    d_sub     <= sub;
  end

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  logic                                   d_valid,
  input  logic [cpu_isa_pkg::reg_idx_width-1:0]  d_rd,
  input  logic [31:0]                            d_rs1_val,
  input  logic [31:0]                            d_rs2_val,
  input  logic [cpu_isa_pkg::reg_idx_width-1:0]  d_rs1,
  input  logic [cpu_isa_pkg::reg_idx_width-1:0]  d_rs2,
  input  logic [31:0]                            d_imm,
  input  logic                                   d_use_imm,
  input  cpu_isa_pkg::alu_op_e                   d_alu_op,
  input  logic                                   d_sub,
  input  logic                                   d_we,
  output logic                                   wb_valid,
  output logic [cpu_isa_pkg::reg_idx_width-1:0]  wb_rd,
  output logic [31:0]                            wb_data
);
  import cpu_isa_pkg::*;

  logic        fwd_a;
  logic        fwd_b;
  logic [31:0] op_a;
  logic [31:0] op_b_reg;
  logic [31:0] op_b;
  logic [31:0] result;

  // Previous instruction is still in the writeback register
  assign fwd_a = wb_valid && d_rs1 != '0 && wb_rd == d_rs1;
  assign fwd_b = wb_valid && d_rs2 != '0 && wb_rd == d_rs2;

  assign op_a     = fwd_a ? wb_data : d_rs1_val;
  assign op_b_reg = fwd_b ? wb_data : d_rs2_val;
  assign op_b     = d_use_imm ? d_imm : op_b_reg;

  always_comb
  begin
    result = '0;
    case (d_alu_op)
      alu_add: result = d_sub ? op_a - op_b : op_a + op_b;
      alu_and: result = op_a & op_b;
      alu_or:  result = op_a | op_b;
      alu_xor: result = op_a ^ op_b;
    endcase
  end

  // wb_valid marks a real register write
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      wb_valid <= 1'b0;
    else
      wb_valid <= d_valid && d_we;
  end

  always_ff @(posedge clk)
  begin
    wb_rd   <= d_rd;
    wb_data <= result;
  end

endmodule

//--- logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
  parameter int imem_depth = 64
) (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic                                 imem_we,
  input  logic [$clog2(imem_depth)-1:0]        imem_addr,
  input  logic [31:0]                          imem_wdata,
  input  logic                                 start,
  input  logic [cpu_bus_pkg::count_width-1:0]  count,
  output logic                                 fetching,
  output logic                                 f_valid,
  output logic [31:0]                          f_instr
);
  import cpu_bus_pkg::*;

  logic [31:0]            imem [imem_depth];
  logic [count_width-1:0] pc;
  logic [count_width-1:0] count_q;

  // Host writes land here between runs
  always_ff @(posedge clk)
  begin
    if (imem_we)
      imem[imem_addr] <= imem_wdata;
  end

  assign fetching = pc < count_q;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pc      <= '0;
      count_q <= '0;
      f_valid <= 1'b0;
    end
    else if (start)
    begin
      pc      <= '0;
      count_q <= count;
      f_valid <= 1'b0;
    end
    else
    begin
      f_valid <= fetching;
      if (fetching)
        pc <= pc + 1'b1;
    end
  end

  // One word per cycle, no bubbles
  always_ff @(posedge clk)
  begin
    if (fetching)
      f_instr <= imem[pc[$clog2(imem_depth)-1:0]];
  end

endmodule

//--- logic/mini_core.sv
`timescale 1ns/1ps

module mini_core #(
  parameter int imem_depth = 64
) (
  input  logic                                    clk,
  input  logic                                    arst_n,
  input  logic                                    psel,
  input  logic                                    penable,
  input  logic                                    pwrite,
  input  logic [cpu_bus_pkg::apb_addr_width-1:0]  paddr,
  input  logic [31:0]                             pwdata,
  output logic [31:0]                             prdata,
  output logic                                    pready,
  output logic                                    pslverr
);
  import cpu_isa_pkg::*;
  import cpu_bus_pkg::*;

  logic                          imem_we;
  logic [$clog2(imem_depth)-1:0] imem_addr;
  logic [31:0]                   imem_wdata;
  logic                          start;
  logic [count_width-1:0]        count;
  logic                          fetching;
  logic                          f_valid;
  logic [31:0]                   f_instr;
  logic [reg_idx_width-1:0]      rf_rs1, rf_rs2;
  logic [31:0]                   rf_rs1_data, rf_rs2_data;
  logic                          d_valid, d_use_imm, d_sub, d_we;
  logic [reg_idx_width-1:0]      d_rd, d_rs1, d_rs2;
  logic [31:0]                   d_rs1_val, d_rs2_val, d_imm;
  alu_op_e                       d_alu_op;
  logic                          wb_valid;
  logic [reg_idx_width-1:0]      wb_rd;
  logic [31:0]                   wb_data;
  logic [reg_idx_width-1:0]      dbg_idx;
  logic [31:0]                   dbg_data;

  apb_ctrl #(.imem_depth(imem_depth)) u_apb_ctrl (
    .clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .fetching(fetching), .f_valid(f_valid), .d_valid(d_valid), .wb_valid(wb_valid),
    .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
    .start(start), .count(count), .dbg_idx(dbg_idx), .dbg_data(dbg_data)
  );

  fetch_stage #(.imem_depth(imem_depth)) u_fetch_stage (
    .clk(clk), .arst_n(arst_n), .imem_we(imem_we), .imem_addr(imem_addr),
    .imem_wdata(imem_wdata), .start(start), .count(count),
    .fetching(fetching), .f_valid(f_valid), .f_instr(f_instr)
  );

  decode_stage u_decode_stage (
    .clk(clk), .arst_n(arst_n), .f_valid(f_valid), .f_instr(f_instr),
    .rf_rs1(rf_rs1), .rf_rs2(rf_rs2), .rf_rs1_data(rf_rs1_data), .rf_rs2_data(rf_rs2_data),
    .d_valid(d_valid), .d_rd(d_rd), .d_rs1_val(d_rs1_val), .d_rs2_val(d_rs2_val),
    .d_rs1(d_rs1), .d_rs2(d_rs2), .d_imm(d_imm), .d_use_imm(d_use_imm),
    .d_alu_op(d_alu_op), .d_sub(d_sub), .d_we(d_we)
  );

  execute_stage u_execute_stage (
    .clk(clk), .arst_n(arst_n), .d_valid(d_valid), .d_rd(d_rd),
    .d_rs1_val(d_rs1_val), .d_rs2_val(d_rs2_val), .d_rs1(d_rs1), .d_rs2(d_rs2),
    .d_imm(d_imm), .d_use_imm(d_use_imm), .d_alu_op(d_alu_op), .d_sub(d_sub),
    .d_we(d_we), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
  );

  register_file u_register_file (
    .clk(clk), .arst_n(arst_n), .we(wb_valid), .wr_idx(wb_rd), .wr_data(wb_data),
    .rs1(rf_rs1), .rs2(rf_rs2), .rs1_data(rf_rs1_data), .rs2_data(rf_rs2_data),
    .dbg_idx(dbg_idx), .dbg_data(dbg_data)
  );

endmodule

//--- logic/register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  logic                                   we,
  input  logic [cpu_isa_pkg::reg_idx_width-1:0]  wr_idx,
  input  logic [31:0]                            wr_data,
  input  logic [cpu_isa_pkg::reg_idx_width-1:0]  rs1,
  input  logic [cpu_isa_pkg::reg_idx_width-1:0]  rs2,
  output logic [31:0]                            rs1_data,
  output logic [31:0]                            rs2_data,
  input  logic [cpu_isa_pkg::reg_idx_width-1:0]  dbg_idx,
  output logic [31:0]                            dbg_data
);
  import cpu_isa_pkg::*;

  localparam int num_regs = 1 << reg_idx_width;

  logic [31:0] regs [num_regs];

  // Same-cycle write bypassed to the pipeline ports but never for x0
  function automatic logic [31:0] read_port(input logic [reg_idx_width-1:0] idx);
    return (we && idx != '0 && idx == wr_idx) ? wr_data : regs[idx];
  endfunction

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < num_regs; i++)
        regs[i] <= '0;
    end
    else if (we && wr_idx != '0)
      regs[wr_idx] <= wr_data;
  end

  always_comb
  begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

  // x0 is never written so it stays at its reset value
  assign dbg_data = regs[dbg_idx];

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_mini_core -o tb_mini_core_sim
./obj_dir/tb_mini_core_sim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Some tests failed" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
if ! grep -q "All tests passed" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
echo "Simulation passed"

//--- sim/mini_core_assertions.sv
`timescale 1ns/1ps

module mini_core_assertions (
  input logic clk,
  input logic arst_n,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic start,
  input logic running,
  input logic done
);

  int slverr_fails = 0;
  int state_fails  = 0;
  int start_fails  = 0;
  int ready_fails  = 0;
  int failures;

  assign failures = slverr_fails + state_fails + start_fails + ready_fails;

  // Error response only inside an access phase
  slverr_in_access: assert property (@(posedge clk) disable iff (!arst_n)
    pslverr |-> psel && penable)
  else
  begin
    slverr_fails++;
    $error("pslverr raised outside an access phase");
  end

  running_xor_done: assert property (@(posedge clk) disable iff (!arst_n)
    !(running && done))
  else
  begin
    state_fails++;
    $error("running and done set together");
  end

  start_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
    start |-> !running)
  else
  begin
    start_fails++;
    $error("start pulsed while running");
  end

  // Zero wait states
  ready_in_access: assert property (@(posedge clk) disable iff (!arst_n)
    psel && penable |-> pready)
  else
  begin
    ready_fails++;
    $error("pready low in an access phase");
  end

endmodule

bind apb_ctrl mini_core_assertions u_mini_core_assertions (
  .clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pready(pready),
  .pslverr(pslverr), .start(start), .running(running), .done(done)
);

//--- sim/tb_mini_core.sv
`timescale 1ns/1ps

module tb_mini_core;
  import cpu_isa_pkg::*;
  import cpu_bus_pkg::*;

  localparam int clk_period = 100;
  localparam int imem_depth = 64;
  localparam int num_runs   = 8;
  localparam int max_len    = 64;
  localparam int reg_count  = 32;
  // Three cycles per APB access plus room for probes and status polls
  localparam int cycles_per_run = 3 * (max_len + reg_count) + 400;

  logic                      clk;
  logic                      arst_n;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [apb_addr_width-1:0] paddr;
  logic [31:0]               pwdata;
  logic [31:0]               prdata;
  logic                      pready;
  logic                      pslverr;

  integer      seed;
  int          errors;
  int          checks;
  int          assert_fails;
  logic [31:0] model_regs [reg_count];
  logic [31:0] program_words [max_len];
  logic [31:0] rd_data;
  logic        rd_err;

  mini_core #(.imem_depth(imem_depth)) u_mini_core (
    .clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial
  begin
    repeat ((num_runs + 1) * cycles_per_run) @(posedge clk);
    $display("Timeout: the test sequence did not finish in time");
    $display("Some tests failed");
    $finish;
  end

  // Setup and access phases followed by one idle cycle
  task automatic apb_access(input logic write, input logic [apb_addr_width-1:0] addr,
                            input logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    rd_data = prdata;
    rd_err  = pslverr;
    check_value("pready in access phase", 32'(pready), 32'h1);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic make_instr(output logic [31:0] w);
    int          sel;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    sel = int'($unsigned($random(seed)) % 11);
    // Small register range keeps dependences frequent
    rd  = 5'($random(seed) & 7);
    rs1 = 5'($random(seed) & 7);
    rs2 = 5'($random(seed) & 7);
    imm = 12'($random(seed));
    case (sel)
      0:       w = {7'h00, rs2, rs1, funct3_add_sub, rd, opcode_op};
      1:       w = {7'h20, rs2, rs1, funct3_add_sub, rd, opcode_op};
      2:       w = {7'h00, rs2, rs1, funct3_xor, rd, opcode_op};
      3:       w = {7'h00, rs2, rs1, funct3_or, rd, opcode_op};
      4:       w = {7'h00, rs2, rs1, funct3_and, rd, opcode_op};
      5:       w = {imm, rs1, funct3_add_sub, rd, opcode_op_imm};
      6:       w = {imm, rs1, funct3_xor, rd, opcode_op_imm};
      7:       w = {imm, rs1, funct3_or, rd, opcode_op_imm};
      8:       w = {imm, rs1, funct3_and, rd, opcode_op_imm};
      default: w = $random(seed);
    endcase
  endtask

  // Sequential reference executing one instruction at a time
  task automatic model_exec(input logic [31:0] w);
    logic [6:0]  opcode;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        ok;
    opcode = w[6:0];
    rd     = w[11:7];
    f3     = w[14:12];
    a      = model_regs[w[19:15]];
    if (opcode == opcode_op)
      b = model_regs[w[24:20]];
    else
      b = {{20{w[31]}}, w[31:20]};
    ok  = opcode == opcode_op || opcode == opcode_op_imm;
    res = '0;
    case (f3)
      // Instruction bit 30 is funct7 bit 5
      funct3_add_sub: res = (opcode == opcode_op && w[30]) ? a - b : a + b;
      funct3_xor:     res = a ^ b;
      funct3_or:      res = a | b;
      funct3_and:     res = a & b;
      default:        ok = 1'b0;
    endcase
    if (ok && rd != 5'd0)
      model_regs[rd] = res;
  endtask

  task automatic read_all_regs();
    for (int i = 0; i < reg_count; i++)
    begin
      apb_access(1'b0, reg_base + 12'(i * 4), 32'h0);
      check_value("register read pslverr", 32'(rd_err), 32'h0);
      check_value($sformatf("register x%0d", i), rd_data, model_regs[i]);
    end
  endtask

  task automatic probe_unmapped();
    apb_access(1'b1, 12'h100, 32'hffff_ffff);
    check_value("pslverr at 0x100", 32'(rd_err), 32'h1);
    apb_access(1'b0, 12'h480, 32'h0);
    check_value("pslverr at 0x480", 32'(rd_err), 32'h1);
    apb_access(1'b1, 12'h802, 32'h8000_00ff);
    check_value("pslverr at 0x802", 32'(rd_err), 32'h1);
    apb_access(1'b0, 12'hc00, 32'h0);
    check_value("pslverr at 0xc00", 32'(rd_err), 32'h1);
    apb_access(1'b0, 12'h401, 32'h0);
    check_value("pslverr at 0x401", 32'(rd_err), 32'h1);
  endtask

  task automatic run_program(input int len);
    logic [31:0] w;
    logic        done_seen;
    for (int i = 0; i < len; i++)
    begin
      make_instr(w);
      program_words[i] = w;
      apb_access(1'b1, imem_base + 12'(i * 4), w);
      check_value("instruction write pslverr", 32'(rd_err), 32'h0);
    end
    apb_access(1'b1, ctrl_addr, (32'd1 << ctrl_run_bit) | 32'(len));
    check_value("control write pslverr", 32'(rd_err), 32'h0);
    if (len >= 16)
    begin
      apb_access(1'b0, reg_base + 12'h004, 32'h0);
      check_value("register read while running", 32'(rd_err), 32'h1);
      // ADDI x1 into the last slot is refused while the program runs
      apb_access(1'b1, imem_base + 12'((len - 1) * 4),
                 {12'h123, 5'd0, funct3_add_sub, 5'd1, opcode_op_imm});
      check_value("instruction write while running", 32'(rd_err), 32'h1);
      apb_access(1'b1, ctrl_addr, 32'd1 << ctrl_run_bit);
      check_value("control write while running", 32'(rd_err), 32'h1);
      apb_access(1'b0, 12'hc00, 32'h0);
      check_value("unmapped read while running", 32'(rd_err), 32'h1);
    end
    for (int i = 0; i < len; i++)
      model_exec(program_words[i]);
    done_seen = 1'b0;
    while (!done_seen)
    begin
      apb_access(1'b0, ctrl_addr, 32'h0);
      check_value("status read pslverr", 32'(rd_err), 32'h0);
      done_seen = rd_data[stat_done_bit];
    end
    check_value("status after run", rd_data, (32'd1 << stat_done_bit) | 32'(len));
    read_all_regs();
  endtask

  initial
  begin
    int len;
    seed    = 32'ha045;
    errors  = 0;
    checks  = 0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    rd_data = '0;
    rd_err  = 1'b0;
    arst_n  = 1'b0;
    for (int i = 0; i < reg_count; i++)
      model_regs[i] = '0;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;

    apb_access(1'b0, ctrl_addr, 32'h0);
    check_value("status after reset", rd_data, 32'h0);
    check_value("status read pslverr", 32'(rd_err), 32'h0);
    read_all_regs();
    probe_unmapped();
    apb_access(1'b0, ctrl_addr, 32'h0);
    check_value("status after unmapped accesses", rd_data, 32'h0);

    for (int r = 0; r < num_runs; r++)
    begin
      if (r == 0)
        len = max_len;
      else if (r == 1)
        len = 0;
      else
        len = 1 + int'($unsigned($random(seed)) % max_len);
      run_program(len);
    end

    assert_fails = u_mini_core.u_apb_ctrl.u_mini_core_assertions.failures;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

//--- vlog.f
logic/cpu_isa_pkg.sv
logic/cpu_bus_pkg.sv
logic/apb_ctrl.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/register_file.sv
logic/mini_core.sv
sim/mini_core_assertions.sv
sim/tb_mini_core.sv
